// ==== design/glyph_rom.sv ====
`timescale 1ns/1ps

module glyph_rom import text_overlay_pkg::*; #(
   parameter font_e FONT  = FONT_LARGE,
   parameter type   ROW_T = large_row_t
) (
   input  logic          clk,
   input  logic          reset,
   input  glyph_lookup_t i_lookup,
   output logic          o_pixel_on
);

   // ------------------------------
   // Large font, 8x8
   // ------------------------------
   // Row 0 left blank in every letter
   localparam large_row_t LARGE_G [LARGE_H] = '{8'b00000000, 8'b00001110, 8'b00010001,
      8'b00000001, 8'b00000001, 8'b00011001, 8'b00010001, 8'b00001110};
   localparam large_row_t LARGE_A [LARGE_H] = '{8'b00000000, 8'b00001110, 8'b00010001,
      8'b00010001, 8'b00010001, 8'b00011111, 8'b00010001, 8'b00010001};
   localparam large_row_t LARGE_M [LARGE_H] = '{8'b00000000, 8'b00011011, 8'b00010101,
      8'b00010001, 8'b00010001, 8'b00010001, 8'b00010001, 8'b00010001};
   localparam large_row_t LARGE_E [LARGE_H] = '{8'b00000000, 8'b00011111, 8'b00000001,
      8'b00000001, 8'b00001111, 8'b00000001, 8'b00000001, 8'b00011111};
   localparam large_row_t LARGE_O [LARGE_H] = '{8'b00000000, 8'b00001110, 8'b00010001,
      8'b00010001, 8'b00010001, 8'b00010001, 8'b00010001, 8'b00001110};
   localparam large_row_t LARGE_V [LARGE_H] = '{8'b00000000, 8'b00010001, 8'b00010001,
      8'b00010001, 8'b00010001, 8'b00010001, 8'b00001010, 8'b00000100};
   localparam large_row_t LARGE_R [LARGE_H] = '{8'b00000000, 8'b00001111, 8'b00010001,
      8'b00010001, 8'b00001111, 8'b00001001, 8'b00010001, 8'b00010001};

   // ------------------------------
   // Small font, 3x12
   // ------------------------------
   localparam small_row_t SMALL_N [SMALL_H] = '{3'b011, 3'b101, 3'b101, 3'b101,
      3'b101, 3'b101, 3'b101, 3'b101, 3'b101, 3'b101, 3'b101, 3'b101};
   localparam small_row_t SMALL_A [SMALL_H] = '{3'b111, 3'b101, 3'b101, 3'b101,
      3'b101, 3'b101, 3'b111, 3'b101, 3'b101, 3'b101, 3'b101, 3'b101};
   localparam small_row_t SMALL_M [SMALL_H] = '{3'b101, 3'b111, 3'b111, 3'b111,
      3'b111, 3'b101, 3'b101, 3'b101, 3'b101, 3'b101, 3'b101, 3'b101};
   localparam small_row_t SMALL_E [SMALL_H] = '{3'b111, 3'b001, 3'b001, 3'b001,
      3'b001, 3'b001, 3'b111, 3'b001, 3'b001, 3'b001, 3'b001, 3'b111};
   localparam small_row_t SMALL_S [SMALL_H] = '{3'b111, 3'b001, 3'b001, 3'b001,
      3'b001, 3'b001, 3'b111, 3'b100, 3'b100, 3'b100, 3'b100, 3'b111};
   localparam small_row_t SMALL_C [SMALL_H] = '{3'b111, 3'b001, 3'b001, 3'b001,
      3'b001, 3'b001, 3'b001, 3'b001, 3'b001, 3'b001, 3'b001, 3'b111};
   localparam small_row_t SMALL_O [SMALL_H] = '{3'b111, 3'b101, 3'b101, 3'b101,
      3'b101, 3'b101, 3'b101, 3'b101, 3'b101, 3'b101, 3'b101, 3'b111};
   localparam small_row_t SMALL_R [SMALL_H] = '{3'b111, 3'b101, 3'b101, 3'b101,
      3'b101, 3'b101, 3'b011, 3'b101, 3'b101, 3'b101, 3'b101, 3'b101};

   ROW_T row_bits;
   ROW_T shifted;

   function automatic large_row_t large_row(input glyph_code_t code, input logic [3:0] row);
      large_row_t bits;
      case (code)
         GLYPH_G: bits = LARGE_G[row[2:0]];
         GLYPH_A: bits = LARGE_A[row[2:0]];
         GLYPH_M: bits = LARGE_M[row[2:0]];
         GLYPH_E: bits = LARGE_E[row[2:0]];
         GLYPH_O: bits = LARGE_O[row[2:0]];
         GLYPH_V: bits = LARGE_V[row[2:0]];
         GLYPH_R: bits = LARGE_R[row[2:0]];
         default: bits = '0;             // Not in this font
      endcase
      if (row >= 4'(LARGE_H)) begin
         bits = '0;
      end
      return bits;
   endfunction

   function automatic small_row_t small_row(input glyph_code_t code, input logic [3:0] row);
      small_row_t bits;
      bits = '0;
      // Rows past the glyph read blank
      if (row < 4'(SMALL_H)) begin
         case (code)
            GLYPH_N: bits = SMALL_N[row];
            GLYPH_A: bits = SMALL_A[row];
            GLYPH_M: bits = SMALL_M[row];
            GLYPH_E: bits = SMALL_E[row];
            GLYPH_S: bits = SMALL_S[row];
            GLYPH_C: bits = SMALL_C[row];
            GLYPH_O: bits = SMALL_O[row];
            GLYPH_R: bits = SMALL_R[row];
            default: bits = '0;
         endcase
      end
      return bits;
   endfunction

   // Row fetch and column select
   always_comb begin
      if (FONT == FONT_LARGE) begin
         row_bits = ROW_T'(large_row(i_lookup.code, i_lookup.row));
      end else begin
         row_bits = ROW_T'(small_row(i_lookup.code, i_lookup.row));
      end
      shifted = row_bits >> i_lookup.col;   // Column lands in bit 0
   end

   // Pipeline stage 2
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         o_pixel_on <= 1'b0;
      end else begin
         o_pixel_on <= i_lookup.hit & shifted[0];
      end
   end

endmodule

// ==== design/text_layout_decode.sv ====
`timescale 1ns/1ps

module text_layout_decode import text_overlay_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  pix_coord_t    i_pix_x,
   input  pix_coord_t    i_pix_y,
   output glyph_lookup_t o_large,
   output glyph_lookup_t o_small
);

   glyph_lookup_t large_next;
   glyph_lookup_t small_next;

   // ------------------------------
   // Slot box test
   // ------------------------------
   // Offsets wrap when the pixel is left of or above the slot, so a single
   // unsigned compare per axis covers both edges of the box
   function automatic glyph_lookup_t slot_lookup(
      input slot_t      slot,
      input pix_coord_t top,
      input pix_coord_t width,
      input pix_coord_t height,
      input pix_coord_t x,
      input pix_coord_t y
   );
      pix_coord_t    dx;
      pix_coord_t    dy;
      glyph_lookup_t lookup;
      dx = x - slot.x;
      dy = y - top;
      lookup.hit  = (dx < width) && (dy < height);
      lookup.code = slot.code;
      lookup.row  = dy[3:0];
      lookup.col  = dx[2:0];
      return lookup;
   endfunction

   // ------------------------------
   // Walk the caption slot lists
   // ------------------------------
   always_comb begin
      glyph_lookup_t cand;
      large_next = '0;
      small_next = '0;

      // Large font, GAME OVER only
      for (int i = 0; i < GAME_OVER_N; i++) begin
         cand = slot_lookup(GAME_OVER_SLOTS[i], GAME_OVER_Y, pix_coord_t'(LARGE_W),
                            pix_coord_t'(LARGE_H), i_pix_x, i_pix_y);
         if (cand.hit) begin
            large_next = cand;
         end
      end

      // Small font, NAME and SCORE rows never overlap
      for (int i = 0; i < NAME_N; i++) begin
         cand = slot_lookup(NAME_SLOTS[i], NAME_Y, pix_coord_t'(SMALL_W),
                            pix_coord_t'(SMALL_H), i_pix_x, i_pix_y);
         if (cand.hit) begin
            small_next = cand;
         end
      end
      for (int i = 0; i < SCORE_N; i++) begin
         cand = slot_lookup(SCORE_SLOTS[i], SCORE_Y, pix_coord_t'(SMALL_W),
                            pix_coord_t'(SMALL_H), i_pix_x, i_pix_y);
         if (cand.hit) begin
            small_next = cand;
         end
      end
   end

   // Pipeline stage 1
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         o_large <= '0;
         o_small <= '0;
      end else begin
         o_large <= large_next;
         o_small <= small_next;
      end
   end

endmodule

// ==== design/text_overlay.sv ====
`timescale 1ns/1ps

module text_overlay import text_overlay_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  pix_coord_t i_pix_x,
   input  pix_coord_t i_pix_y,
   output logic       o_letter_on
);

   glyph_lookup_t large_lookup;
   glyph_lookup_t small_lookup;
   logic          large_on;
   logic          small_on;

   // ------------------------------
   // Layout decode
   // ------------------------------
   text_layout_decode u_decode (
      .clk     (clk),
      .reset   (reset),
      .i_pix_x (i_pix_x),
      .i_pix_y (i_pix_y),
      .o_large (large_lookup),
      .o_small (small_lookup)
   );

   // ------------------------------
   // Glyph lookup, one ROM per font
   // ------------------------------
   glyph_rom #(
      .FONT  (FONT_LARGE),
      .ROW_T (large_row_t)
   ) u_large_rom (
      .clk        (clk),
      .reset      (reset),
      .i_lookup   (large_lookup),
      .o_pixel_on (large_on)
   );

   glyph_rom #(
      .FONT  (FONT_SMALL),
      .ROW_T (small_row_t)
   ) u_small_rom (
      .clk        (clk),
      .reset      (reset),
      .i_lookup   (small_lookup),
      .o_pixel_on (small_on)
   );

   // Both sources registered, flag valid two cycles after the coordinate
   assign o_letter_on = large_on | small_on;

endmodule

// ==== design/text_overlay_pkg.sv ====
package text_overlay_pkg;

   // ------------------------------
   // Screen coordinates
   // ------------------------------
   localparam int COORD_W = 12;

   typedef logic [COORD_W-1:0] pix_coord_t;

   // ------------------------------
   // Glyphs and fonts
   // ------------------------------
   // Every distinct letter used by the three captions
   typedef enum logic [3:0] {
      GLYPH_G,
      GLYPH_A,
      GLYPH_M,
      GLYPH_E,
      GLYPH_O,
      GLYPH_V,
      GLYPH_R,
      GLYPH_N,
      GLYPH_S,
      GLYPH_C
   } glyph_code_t;

   typedef enum logic {
      FONT_LARGE,
      FONT_SMALL
   } font_e;

   localparam int LARGE_W = 8;
   localparam int LARGE_H = 8;
   localparam int SMALL_W = 3;    // Narrow caption font
   localparam int SMALL_H = 12;

   // Bit c of a row is column c, column 0 at the left edge
   typedef logic [LARGE_W-1:0] large_row_t;
   typedef logic [SMALL_W-1:0] small_row_t;

   // Result of the layout decode for one font
   typedef struct packed {
      logic        hit;           // Pixel inside a slot of this font
      glyph_code_t code;
      logic [3:0]  row;
      logic [2:0]  col;
   } glyph_lookup_t;

   // ------------------------------
   // Caption layout
   // ------------------------------
   typedef struct packed {
      pix_coord_t  x;             // Left edge of the slot
      glyph_code_t code;
   } slot_t;

   localparam pix_coord_t GAME_OVER_Y = 12'd320;
   localparam pix_coord_t NAME_Y      = 12'd120;
   localparam pix_coord_t SCORE_Y     = 12'd220;

   localparam int GAME_OVER_N = 8;
   localparam int NAME_N      = 4;
   localparam int SCORE_N     = 5;

   localparam slot_t GAME_OVER_SLOTS [GAME_OVER_N] = '{
      '{x: 12'd240, code: GLYPH_G},
      '{x: 12'd260, code: GLYPH_A},
      '{x: 12'd280, code: GLYPH_M},
      '{x: 12'd300, code: GLYPH_E},
      '{x: 12'd360, code: GLYPH_O},   // Wide gap between the two words
      '{x: 12'd380, code: GLYPH_V},
      '{x: 12'd400, code: GLYPH_E},
      '{x: 12'd420, code: GLYPH_R}
   };

   localparam slot_t NAME_SLOTS [NAME_N] = '{
      '{x: 12'd300, code: GLYPH_N},
      '{x: 12'd320, code: GLYPH_A},
      '{x: 12'd340, code: GLYPH_M},
      '{x: 12'd360, code: GLYPH_E}
   };

   // Tighter pitch than NAME
   localparam slot_t SCORE_SLOTS [SCORE_N] = '{
      '{x: 12'd300, code: GLYPH_S},
      '{x: 12'd315, code: GLYPH_C},
      '{x: 12'd330, code: GLYPH_O},
      '{x: 12'd345, code: GLYPH_R},
      '{x: 12'd360, code: GLYPH_E}
   };

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build the text overlay testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   -f text_overlay.f \
   --top-module text_overlay_tb \
   -o text_overlay_sim

./obj_dir/text_overlay_sim | tee sim.log

if grep -qx "All checks passed" sim.log; then
   echo "Simulation PASS"
   exit 0
else
   echo "Simulation FAIL"
   exit 1
fi

// ==== sim/text_overlay_ref.svh ====
`ifndef TEXT_OVERLAY_REF_SVH
`define TEXT_OVERLAY_REF_SVH

// Caption letters and the left edge of each slot
localparam int    OVER_TOP    = 320;
localparam string OVER_TXT    = "GAMEOVER";
localparam int    OVER_X [8]  = '{240, 260, 280, 300, 360, 380, 400, 420};
localparam int    NAME_TOP    = 120;
localparam string NAME_TXT    = "NAME";
localparam int    NAME_X [4]  = '{300, 320, 340, 360};
localparam int    SCORE_TOP   = 220;
localparam string SCORE_TXT   = "SCORE";
localparam int    SCORE_X [5] = '{300, 315, 330, 345, 360};

// ------------------------------
// Glyph pictures
// ------------------------------
// Each row reads left to right and # marks a lit pixel
function automatic string big_picture(byte ch);
   case (ch)
      "G": return {"........", ".###....", "#...#...", "#.......",
                   "#.......", "#..##...", "#...#...", ".###...."};
      "A": return {"........", ".###....", "#...#...", "#...#...",
                   "#...#...", "#####...", "#...#...", "#...#..."};
      "M": return {"........", "##.##...", "#.#.#...", "#...#...",
                   "#...#...", "#...#...", "#...#...", "#...#..."};
      "E": return {"........", "#####...", "#.......", "#.......",
                   "####....", "#.......", "#.......", "#####..."};
      "O": return {"........", ".###....", "#...#...", "#...#...",
                   "#...#...", "#...#...", "#...#...", ".###...."};
      "V": return {"........", "#...#...", "#...#...", "#...#...",
                   "#...#...", "#...#...", ".#.#....", "..#....."};
      "R": return {"........", "####....", "#...#...", "#...#...",
                   "####....", "#..#....", "#...#...", "#...#..."};
      default: return "";
   endcase
endfunction

function automatic string small_picture(byte ch);
   case (ch)
      "N": return {"##.", "#.#", "#.#", "#.#", "#.#", "#.#",
                   "#.#", "#.#", "#.#", "#.#", "#.#", "#.#"};
      "A": return {"###", "#.#", "#.#", "#.#", "#.#", "#.#",
                   "###", "#.#", "#.#", "#.#", "#.#", "#.#"};
      "M": return {"#.#", "###", "###", "###", "###", "#.#",
                   "#.#", "#.#", "#.#", "#.#", "#.#", "#.#"};
      "E": return {"###", "#..", "#..", "#..", "#..", "#..",
                   "###", "#..", "#..", "#..", "#..", "###"};
      "S": return {"###", "#..", "#..", "#..", "#..", "#..",
                   "###", "..#", "..#", "..#", "..#", "###"};
      "C": return {"###", "#..", "#..", "#..", "#..", "#..",
                   "#..", "#..", "#..", "#..", "#..", "###"};
      "O": return {"###", "#.#", "#.#", "#.#", "#.#", "#.#",
                   "#.#", "#.#", "#.#", "#.#", "#.#", "###"};
      "R": return {"###", "#.#", "#.#", "#.#", "#.#", "#.#",
                   "##.", "#.#", "#.#", "#.#", "#.#", "#.#"};
      default: return "";
   endcase
endfunction

// Lit only inside the slot box and where the picture shows #
function automatic bit slot_pixel(byte ch, bit big, int x0, int top, int x, int y);
   int    w;
   int    h;
   string pic;
   w   = big ? 8 : 3;
   h   = big ? 8 : 12;
   pic = big ? big_picture(ch) : small_picture(ch);
   if (x < x0 || x >= x0 + w || y < top || y >= top + h) begin
      return 1'b0;
   end
   return pic[(y - top) * w + (x - x0)] == "#";
endfunction

function automatic bit expected_on(int x, int y);
   bit on;
   on = 1'b0;
   for (int i = 0; i < 8; i++) begin
      on |= slot_pixel(OVER_TXT[i], 1'b1, OVER_X[i], OVER_TOP, x, y);
   end
   for (int i = 0; i < 4; i++) begin
      on |= slot_pixel(NAME_TXT[i], 1'b0, NAME_X[i], NAME_TOP, x, y);
   end
   for (int i = 0; i < 5; i++) begin
      on |= slot_pixel(SCORE_TXT[i], 1'b0, SCORE_X[i], SCORE_TOP, x, y);
   end
   return on;
endfunction

`endif

// ==== sim/text_overlay_tb.sv ====
`timescale 1ns/1ps

module text_overlay_tb import text_overlay_pkg::*; ();

   localparam int CLK_PERIOD  = 10;
   localparam int STIM_CYCLES = 25000;   // All rasters, edges and the random run

   `include "text_overlay_ref.svh"

   logic       clk;
   logic       reset;
   pix_coord_t i_pix_x;
   pix_coord_t i_pix_y;
   logic       o_letter_on;

   bit want_d1;
   bit want_d2;
   bit valid_d1;
   bit valid_d2;
   int checks = 0;
   int errors = 0;
   int tests  = 0;

   text_overlay text_overlay_i (
      .clk         (clk),
      .reset       (reset),
      .i_pix_x     (i_pix_x),
      .i_pix_y     (i_pix_y),
      .o_letter_on (o_letter_on)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ------------------------------
   // Expected flag pipeline
   // ------------------------------
   always @(posedge clk or posedge reset) begin
      if (reset) begin
         want_d1  <= 1'b0;
         want_d2  <= 1'b0;
         valid_d1 <= 1'b0;
         valid_d2 <= 1'b0;
      end else begin
         want_d1  <= expected_on(int'(i_pix_x), int'(i_pix_y));   // Coordinate DUT just took
         want_d2  <= want_d1;
         valid_d1 <= 1'b1;
         valid_d2 <= valid_d1;
      end
   end

   always @(negedge clk) begin
      if (valid_d2) begin
         checks++;
      end
   end

   // Flag follows the coordinate from two edges earlier
   flag_matches: assert property (@(negedge clk) disable iff (reset)
      !valid_d2 || (o_letter_on == want_d2))
      else begin
         errors++;
         $display("error at %0t: o_letter_on = %b, expected %b", $time, o_letter_on, want_d2);
      end

   // Low in reset and until the first real pixel arrives
   reset_level: assert property (@(negedge clk) valid_d2 || !o_letter_on)
      else begin
         errors++;
         $display("error at %0t: o_letter_on = %b, expected 0", $time, o_letter_on);
      end

   // ------------------------------
   // Stimulus
   // ------------------------------
   task automatic drive(input int x, input int y);
      @(posedge clk);
      i_pix_x <= pix_coord_t'(x);
      i_pix_y <= pix_coord_t'(y);
   endtask

   task automatic raster(input int x0, input int y0, input int w, input int h);
      for (int r = 0; r < h; r++) begin
         for (int c = 0; c < w; c++) begin
            drive(x0 + c, y0 + r);
         end
      end
   endtask

   // One pixel ring around the box, then the gap up to the next slot
   task automatic slot_edges(input int x0, input int next_x, input int y0, input int w,
                             input int h);
      for (int r = -1; r <= h; r++) begin
         for (int c = -1; c <= w; c++) begin
            if (r < 0 || r == h || c < 0 || c == w) begin
               drive(x0 + c, y0 + r);
            end
         end
      end
      if (next_x > 0) begin
         raster(x0 + w, y0, next_x - x0 - w, h);
      end
   endtask

   task automatic end_test(input string name, input int first_error);
      repeat (3) @(posedge clk);   // Drain the two stage pipeline
      tests++;
      $display("%s: done, %0d errors", name, errors - first_error);
   endtask

   initial begin
      int mark;
      void'($urandom(32'h3cdb576b));
      reset   = 1'b1;
      // Lit G pixel held through reset
      i_pix_x = pix_coord_t'(OVER_X[0] + 1);
      i_pix_y = pix_coord_t'(OVER_TOP + 1);
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      end_test("reset", 0);

      mark = errors;
      for (int i = 0; i < 8; i++) begin
         raster(OVER_X[i], OVER_TOP, 8, 8);
      end
      end_test("large font", mark);

      mark = errors;
      for (int i = 0; i < 4; i++) begin
         raster(NAME_X[i], NAME_TOP, 3, 12);
      end
      for (int i = 0; i < 5; i++) begin
         raster(SCORE_X[i], SCORE_TOP, 3, 12);
      end
      end_test("small font", mark);

      mark = errors;
      for (int i = 0; i < 8; i++) begin
         slot_edges(OVER_X[i], (i < 7) ? OVER_X[i + 1] : 0, OVER_TOP, 8, 8);
      end
      for (int i = 0; i < 4; i++) begin
         slot_edges(NAME_X[i], (i < 3) ? NAME_X[i + 1] : 0, NAME_TOP, 3, 12);
      end
      for (int i = 0; i < 5; i++) begin
         slot_edges(SCORE_X[i], (i < 4) ? SCORE_X[i + 1] : 0, SCORE_TOP, 3, 12);
      end
      end_test("boundaries", mark);

      mark = errors;
      for (int i = 0; i < 20000; i++) begin
         drive($urandom_range(639, 0), $urandom_range(479, 0));
      end
      end_test("random pixels", mark);

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0 && checks > 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // Watchdog at twice the stimulus length
   initial begin
      #(2 * STIM_CYCLES * CLK_PERIOD);
      $display("timeout after %0d cycles, the tests did not finish", 2 * STIM_CYCLES);
      $display("Checks failed");
      $finish;
   end

endmodule

// ==== text_overlay.f ====
+incdir+sim
design/text_overlay_pkg.sv
design/text_layout_decode.sv
design/glyph_rom.sv
design/text_overlay.sv
sim/text_overlay_tb.sv
